// File: design/board_io_defines.svh
`ifndef BOARD_IO_DEFINES_SVH
`define BOARD_IO_DEFINES_SVH

// Byte address map of the CPU bus
`define RAM_BASE        16'h1000
`define RAM_WORDS       1024
`define UART_ADDR       16'h2000
`define KEY_ADDR        16'h2004

// Key events held between keyboard and CPU, power of two
`define KEY_FIFO_DEPTH  8

// System clocks without a PS/2 edge before a partial frame is dropped
`define PS2_TIMEOUT     4096

`endif

// File: design/board_io_pkg.sv
package board_io_pkg;

    // One decoded keyboard event
    typedef struct packed {
        logic       released;
        logic [7:0] code;
    } key_event_t;

    // CPU load/store port, read and write are single-cycle strobes
    typedef struct packed {
        logic        read;
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // Byte strobe towards the UART
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } uart_tx_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        OFFER
    } ps2_state_e;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_UART,
        REGION_KEY
    } bus_region_e;

    // Acknowledge side of the key register handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT
    } hs_state_e;

endpackage

// File: design/ps2_receiver.sv
`timescale 1ns/1ps
`include "board_io_defines.svh"

module ps2_receiver (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ps2_clk,
    input  logic                     ps2_dat,
    output logic                     ev_req,
    output board_io_pkg::key_event_t ev_data,
    input  logic                     ev_ack
);
    import board_io_pkg::*;

    localparam int TO_W = $clog2(`PS2_TIMEOUT);

    logic [1:0]      clk_sync;
    logic [1:0]      dat_sync;
    logic            clk_prev;
    logic            ps2_fall;
    ps2_state_e      state;
    logic [3:0]      bit_cnt;
    logic [9:0]      shreg;
    logic [9:0]      frame;
    logic            frame_done;
    logic            frame_ok;
    logic [TO_W-1:0] idle_cnt;
    logic            released_pend;

    // Both PS/2 lines idle high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign ps2_fall = clk_prev & ~clk_sync[1];

    // New bit enters at the top, so data ends up LSB first in frame[7:0]
    assign frame      = {dat_sync[1], shreg[9:1]};
    assign frame_done = (state == SHIFT) && ps2_fall && (bit_cnt == 4'd9);
    // Odd parity across data plus parity bit, stop bit high
    assign frame_ok   = (^frame[8:0]) && frame[9];

    always_ff @(posedge clk) begin
        if (state == SHIFT && ps2_fall) begin
            shreg <= frame;
        end
        if (frame_done) begin
            ev_data <= '{released: released_pend, code: frame[7:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            bit_cnt       <= '0;
            idle_cnt      <= '0;
            released_pend <= 1'b0;
            ev_req        <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                    // Start bit must read low
                    if (ps2_fall && !dat_sync[1]) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (ps2_fall) begin
                        idle_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (frame_done) begin
                            state <= IDLE;
                            if (frame_ok) begin
                                // Break prefix only marks the next code
                                if (frame[7:0] == 8'hF0) begin
                                    released_pend <= 1'b1;
                                end else begin
                                    released_pend <= 1'b0;
                                    ev_req        <= 1'b1;
                                    state         <= OFFER;
                                end
                            end
                        end
                    end else if (idle_cnt == TO_W'(`PS2_TIMEOUT - 1)) begin
                        // Stalled frame
                        state <= IDLE;
                    end else begin
                        idle_cnt <= idle_cnt + TO_W'(1);
                    end
                end
                OFFER: begin
                    // PS/2 edges ignored until the four-phase cycle closes
                    if (ev_req && ev_ack) begin
                        ev_req <= 1'b0;
                    end else if (!ev_req && !ev_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/key_fifo.sv
`timescale 1ns/1ps
`include "board_io_defines.svh"

module key_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ev_req,
    input  board_io_pkg::key_event_t ev_data,
    output logic                     ev_ack,
    output logic                     key_req,
    output board_io_pkg::key_event_t key_data,
    input  logic                     key_ack
);
    import board_io_pkg::*;

    localparam int DEPTH = `KEY_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    key_event_t       mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_en;
    logic             pop;
    logic             key_ack_d;

    assign full  = (count == (PTR_W+1)'(DEPTH));
    // Accept once per request, only with space left
    assign wr_en = ev_req && !ev_ack && !full;
    // Pop on the rising edge of the consumer's ack
    assign pop   = key_ack && !key_ack_d;

    assign key_req  = (count != '0) && !key_ack;
    assign key_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= ev_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            ev_ack    <= 1'b0;
            key_ack_d <= 1'b0;
        end else begin
            key_ack_d <= key_ack;
            if (wr_en) begin
                ev_ack <= 1'b1;
                wr_ptr <= wr_ptr + PTR_W'(1);
            end else if (!ev_req) begin
                ev_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, pop})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/bus_controller.sv
`timescale 1ns/1ps
`include "board_io_defines.svh"

module bus_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  board_io_pkg::bus_req_t   bus_req,
    output logic [31:0]              bus_read_data,
    output board_io_pkg::uart_tx_t   uart_tx,
    input  logic                     key_req,
    input  board_io_pkg::key_event_t key_data,
    output logic                     key_ack
);
    import board_io_pkg::*;

    localparam int          IDX_W   = $clog2(`RAM_WORDS);
    localparam logic [15:0] RAM_END = `RAM_BASE + 16'(`RAM_WORDS * 4);

    logic [31:0]      ram [0:`RAM_WORDS-1];
    bus_region_e      region;
    logic [15:0]      ram_off;
    logic [IDX_W-1:0] ram_idx;
    hs_state_e        hs_state;
    logic             key_read;
    logic             key_avail;
    logic             uart_write;

    // Address decode
    always_comb begin
        if (bus_req.addr >= `RAM_BASE && bus_req.addr < RAM_END) begin
            region = REGION_RAM;
        end else if (bus_req.addr == `UART_ADDR) begin
            region = REGION_UART;
        end else if (bus_req.addr == `KEY_ADDR) begin
            region = REGION_KEY;
        end else begin
            region = REGION_NONE;
        end
    end

    // Byte address to word index
    assign ram_off = bus_req.addr - `RAM_BASE;
    assign ram_idx = ram_off[IDX_W+1:2];

    assign key_read   = bus_req.read && (region == REGION_KEY);
    assign uart_write = bus_req.write && (region == REGION_UART);
    // No key while a previous acknowledge is still closing
    assign key_avail  = key_req && (hs_state == HS_IDLE);
    assign key_ack    = (hs_state == HS_ACK);

    always_ff @(posedge clk) begin
        if (bus_req.write && region == REGION_RAM) begin
            ram[ram_idx] <= bus_req.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_read_data <= '0;
        end else if (bus_req.read) begin
            case (region)
                REGION_RAM: bus_read_data <= ram[ram_idx];
                // Bit 9 valid, bit 8 released, low byte scan code
                REGION_KEY: bus_read_data <= key_avail ? {22'd0, 1'b1, key_data} : '0;
                default:    bus_read_data <= '0;
            endcase
        end
    end

    // One-cycle UART strobe per write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_tx <= '0;
        end else begin
            uart_tx.valid <= uart_write;
            if (uart_write) begin
                uart_tx.data <= bus_req.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= HS_IDLE;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (key_read && key_req) begin
                        hs_state <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    // FIFO has popped once its request drops
                    if (!key_req) begin
                        hs_state <= HS_WAIT;
                    end
                end
                HS_WAIT: hs_state <= HS_IDLE;
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

endmodule

// File: design/irq_controller.sv
`timescale 1ns/1ps

module irq_controller (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_req,
    input  logic       interrupt_ack,
    output logic [3:0] interrupt_vector,
    output logic       irq_pending
);

    logic key_req_d;
    logic key_rise;

    // One interrupt per key arrival
    assign key_rise    = key_req && !key_req_d;
    assign irq_pending = |interrupt_vector;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_req_d        <= 1'b0;
            interrupt_vector <= '0;
        end else begin
            key_req_d <= key_req;
            // Acknowledge takes priority over a new arrival
            if (interrupt_ack && interrupt_vector != '0) begin
                interrupt_vector <= '0;
            end else if (key_rise) begin
                interrupt_vector <= 4'd1;
            end
        end
    end

endmodule

// File: design/board_io.sv
`timescale 1ns/1ps

module board_io (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   PS2_CLK,
    input  logic                   PS2_DAT,
    input  board_io_pkg::bus_req_t bus_req,
    output logic [31:0]            bus_read_data,
    output board_io_pkg::uart_tx_t uart_tx,
    output logic [3:0]             interrupt_vector,
    input  logic                   interrupt_ack,
    output logic                   LEDR7
);
    import board_io_pkg::*;

    // Receiver to FIFO
    logic       ev_req;
    logic       ev_ack;
    key_event_t ev_data;

    // FIFO to bus controller
    logic       key_req;
    logic       key_ack;
    key_event_t key_data;

    ps2_receiver u_ps2_receiver (
        .clk     (CLOCK_50),
        .rst_n   (KEY0),
        .ps2_clk (PS2_CLK),
        .ps2_dat (PS2_DAT),
        .ev_req  (ev_req),
        .ev_data (ev_data),
        .ev_ack  (ev_ack)
    );

    key_fifo u_key_fifo (
        .clk      (CLOCK_50),
        .rst_n    (KEY0),
        .ev_req   (ev_req),
        .ev_data  (ev_data),
        .ev_ack   (ev_ack),
        .key_req  (key_req),
        .key_data (key_data),
        .key_ack  (key_ack)
    );

    bus_controller u_bus_controller (
        .clk           (CLOCK_50),
        .rst_n         (KEY0),
        .bus_req       (bus_req),
        .bus_read_data (bus_read_data),
        .uart_tx       (uart_tx),
        .key_req       (key_req),
        .key_data      (key_data),
        .key_ack       (key_ack)
    );

    irq_controller u_irq_controller (
        .clk              (CLOCK_50),
        .rst_n            (KEY0),
        .key_req          (key_req),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .irq_pending      (LEDR7)
    );

endmodule

// File: sim/board_io_assertions.sv
`timescale 1ns/1ps

module board_io_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     ev_req,
    input logic                     ev_ack,
    input board_io_pkg::key_event_t ev_data,
    input logic                     key_req,
    input logic                     key_ack,
    input logic                     interrupt_ack,
    input logic [3:0]               interrupt_vector
);

    int failures = 0;

    // Event held until the FIFO takes it
    ev_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ev_req && !ev_ack |=> !ev_req || $stable(ev_data))
    else begin
        $error("ev_data changed while ev_req waited for ev_ack");
        failures++;
    end

    key_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(key_ack) |-> $past(key_req))
    else begin
        $error("key_ack rose without key_req");
        failures++;
    end

    irq_cleared_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        interrupt_ack && interrupt_vector != 4'd0 |-> ##[1:2] interrupt_vector == 4'd0)
    else begin
        $error("interrupt_vector not cleared after interrupt_ack");
        failures++;
    end

endmodule

bind board_io board_io_assertions u_board_io_assertions (
    .clk              (CLOCK_50),
    .rst_n            (KEY0),
    .ev_req           (ev_req),
    .ev_ack           (ev_ack),
    .ev_data          (ev_data),
    .key_req          (key_req),
    .key_ack          (key_ack),
    .interrupt_ack    (interrupt_ack),
    .interrupt_vector (interrupt_vector)
);

// File: sim/board_io_tb.sv
`timescale 1ns/1ps
`include "board_io_defines.svh"

module board_io_tb;
    import board_io_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int HALF_BIT        = 8;
    localparam int FRAME_CYCLES    = 11 * 2 * HALF_BIT + 2 * HALF_BIT;
    localparam int NUM_PRESS       = 6;
    localparam int NUM_FRAMES      = 2 * NUM_PRESS + 10 + 2;
    localparam int NUM_BUS_OPS     = 200;
    localparam int POLL_LIMIT      = 64;
    localparam int WATCHDOG_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES + NUM_BUS_OPS * 20;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    bus_req_t    bus_req;
    logic [31:0] bus_read_data;
    uart_tx_t    uart_tx;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;
    logic        LEDR7;

    // Reference state kept by the comparing process
    logic [31:0] model_ram [0:`RAM_WORDS-1];
    logic [31:0] exp_key_q [$];
    logic        read_due;
    logic [15:0] read_addr;
    logic        uart_due;
    logic [7:0]  uart_byte;
    int          uart_pulses;
    int          errors;
    int          checks;

    board_io u_board_io (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (PS2_CLK),
        .PS2_DAT          (PS2_DAT),
        .bus_req          (bus_req),
        .bus_read_data    (bus_read_data),
        .uart_tx          (uart_tx),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .LEDR7            (LEDR7)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    // Expected key word for one key where F0 marks the next code as released
    function automatic logic [31:0] model_key_read(input logic [7:0] seq [$]);
        logic        released;
        logic [31:0] word;
        released = 1'b0;
        word     = '0;
        foreach (seq[i]) begin
            if (seq[i] == 8'hF0) begin
                released = 1'b1;
            end else begin
                word     = {22'd0, 1'b1, released, seq[i]};
                released = 1'b0;
            end
        end
        return word;
    endfunction

    function automatic logic in_ram(input logic [15:0] addr);
        return (addr >= `RAM_BASE) && (addr < `RAM_BASE + `RAM_WORDS * 4);
    endfunction

    function automatic int ram_index(input logic [15:0] addr);
        return (int'(addr) - int'(`RAM_BASE)) / 4;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge CLOCK_50);
        #10;
    endtask

    task automatic flag_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_board_io.u_board_io_assertions.failures);
    endtask

    // Start bit, data LSB first, odd parity, stop bit
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = bits[i];
            tick(HALF_BIT);
            PS2_CLK = 1'b0;
            tick(HALF_BIT);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        tick(2 * HALF_BIT);
    endtask

    task automatic send_key(input logic release_it, input logic [7:0] code);
        logic [7:0] seq [$];
        if (release_it) begin
            send_frame(8'hF0, 1'b0);
            seq.push_back(8'hF0);
        end
        send_frame(code, 1'b0);
        seq.push_back(code);
        exp_key_q.push_back(model_key_read(seq));
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        bus_req.write = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        tick(1);
        bus_req.write = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        bus_req.read = 1'b1;
        bus_req.addr = addr;
        tick(1);
        bus_req.read = 1'b0;
        data = bus_read_data;
    endtask

    task automatic poll_key(output logic [31:0] word);
        int tries;
        tries = 0;
        word  = '0;
        while (!word[9] && tries < POLL_LIMIT) begin
            bus_read(`KEY_ADDR, word);
            tries++;
        end
        if (!word[9]) begin
            note_failure("Polling the key register never returned a valid key");
        end
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (interrupt_vector != 4'd1 && cycles < 4 * HALF_BIT) begin
            tick(1);
            cycles++;
        end
        checks++;
        assert (interrupt_vector == 4'd1)
        else flag_mismatch($sformatf("interrupt_vector is %0d after a key", interrupt_vector));
        checks++;
        assert (LEDR7 === 1'b1)
        else flag_mismatch("LEDR7 is low while an interrupt is pending");
    endtask

    task automatic ack_irq();
        interrupt_ack = 1'b1;
        tick(1);
        interrupt_ack = 1'b0;
        tick(1);
        checks++;
        assert (interrupt_vector == 4'd0)
        else flag_mismatch($sformatf("interrupt_vector is %0d after ack", interrupt_vector));
        checks++;
        assert (LEDR7 === 1'b0)
        else flag_mismatch("LEDR7 is still high after ack");
    endtask

    // A key read may return zero until the key shows up
    task automatic check_read(input logic [15:0] addr, input logic [31:0] got);
        logic [31:0] exp;
        exp = '0;
        if (in_ram(addr)) begin
            exp = model_ram[ram_index(addr)];
        end else if (addr == `KEY_ADDR && exp_key_q.size() > 0 && got != '0) begin
            exp = exp_key_q.pop_front();
        end
        checks++;
        assert (got === exp)
        else flag_mismatch($sformatf("read of %h returned %h, expected %h", addr, got, exp));
    endtask

    // Outputs sampled mid-cycle one cycle after each strobe
    always @(negedge CLOCK_50) begin
        if (!KEY0) begin
            read_due = 1'b0;
            uart_due = 1'b0;
        end else begin
            if (read_due) begin
                check_read(read_addr, bus_read_data);
            end
            assert (uart_tx.valid === uart_due)
            else flag_mismatch($sformatf("uart_tx.valid is %b, expected %b",
                                         uart_tx.valid, uart_due));
            if (uart_tx.valid === 1'b1) begin
                uart_pulses++;
            end
            if (uart_due) begin
                checks++;
                assert (uart_tx.data === uart_byte)
                else flag_mismatch($sformatf("uart_tx.data is %h, expected %h",
                                             uart_tx.data, uart_byte));
            end
            read_due  = bus_req.read;
            read_addr = bus_req.addr;
            uart_due  = bus_req.write && (bus_req.addr == `UART_ADDR);
            uart_byte = bus_req.wdata[7:0];
            if (bus_req.write && in_ram(bus_req.addr)) begin
                model_ram[ram_index(bus_req.addr)] = bus_req.wdata;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("Watchdog expired after %0d clock cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        report_counts();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] word;
        logic [15:0] addrs [$];
        logic [15:0] addr;
        logic [7:0]  code;
        void'($urandom(32'h5ab39e02));
        errors        = 0;
        checks        = 0;
        uart_pulses   = 0;
        read_due      = 1'b0;
        uart_due      = 1'b0;
        KEY0          = 1'b0;
        PS2_CLK       = 1'b1;
        PS2_DAT       = 1'b1;
        bus_req       = '0;
        interrupt_ack = 1'b0;
        tick(4);
        KEY0 = 1'b1;
        tick(2);

        // Register map right after reset
        bus_read(`KEY_ADDR, word);
        bus_read(16'h0100, word);
        bus_read(16'h3000, word);
        bus_read(`UART_ADDR, word);
        checks++;
        assert (interrupt_vector == 4'd0)
        else flag_mismatch("interrupt_vector not zero after reset");

        // RAM write then read back
        repeat (30) begin
            addr = 16'(`RAM_BASE + 4 * $urandom_range(0, `RAM_WORDS - 1));
            addrs.push_back(addr);
            bus_write(addr, $urandom());
        end
        foreach (addrs[i]) begin
            bus_read(addrs[i], word);
        end

        // Single keys with some released
        repeat (NUM_PRESS) begin
            code = 8'($urandom_range(1, 8'h7f));
            send_key(1'($urandom_range(0, 1)), code);
            wait_irq();
            poll_key(word);
            ack_irq();
        end

        // Ten keys unread so the ninth waits in the receiver and the tenth is dropped
        for (int i = 0; i < 10; i++) begin
            code = 8'($urandom_range(1, 8'h7f));
            if (i < `KEY_FIFO_DEPTH + 1) begin
                send_key(1'b0, code);
            end else begin
                send_frame(code, 1'b0);
            end
        end
        repeat (`KEY_FIFO_DEPTH + 1) begin
            poll_key(word);
        end
        tick(4);
        bus_read(`KEY_ADDR, word);
        ack_irq();

        // Bad parity frame then a good one
        send_frame(8'($urandom_range(1, 8'h7f)), 1'b1);
        send_key(1'b0, 8'($urandom_range(1, 8'h7f)));
        wait_irq();
        poll_key(word);
        tick(4);
        bus_read(`KEY_ADDR, word);
        ack_irq();

        // UART bytes spaced and then back to back
        repeat (8) begin
            bus_write(`UART_ADDR, $urandom());
            tick(2);
        end
        repeat (4) begin
            bus_write(`UART_ADDR, $urandom());
        end
        tick(3);
        checks++;
        assert (uart_pulses == 12)
        else flag_mismatch($sformatf("%0d UART pulses seen, expected 12", uart_pulses));

        report_counts();
        if (errors + u_board_io.u_board_io_assertions.failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/board_io_pkg.sv
design/ps2_receiver.sv
design/key_fifo.sv
design/bus_controller.sv
design/irq_controller.sv
design/board_io.sv
sim/board_io_assertions.sv
sim/board_io_tb.sv
